// File: soc_bus.f
+incdir+common
common/bus_pkg.sv
common/plic_pkg.sv
source/bus_control.sv
ram/ram_port.sv
plic/plic_regs.sv
source/soc_bus.sv
dv/tb_soc_bus.sv

// File: dv/tb_soc_bus.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module tb_soc_bus import bus_pkg::*;;

    // transfers issued over the whole run, used to size the watchdog
    localparam int  n_transfers = 2 + 20 * 10 + 10 * 2 + 2 + 20 + 4 * 6;
    localparam time watchdog_ns = (n_transfers * 8 + 100) * 20;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] address;
    logic [63:0] write_data;
    ls_type_u    ls_type;
    logic        read_enable;
    logic        write_enable;
    logic        ext_irq;
    logic [63:0] read_data;
    logic        read_done;
    logic        write_done;
    logic [63:0] mtimecmp;
    logic        meip;
    logic        msip;

    logic [31:0] lfsr_q = 32'h15de_b5bd;
    logic [7:0]  ram_model [4 * `RAM_WORDS];   // byte image of the RAM
    logic [31:0] pending_model;
    string       test_name;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;

    soc_bus i_dut (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .address      (address),
        .write_data   (write_data),
        .ls_type      (ls_type),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .ext_irq      (ext_irq),
        .read_data    (read_data),
        .read_done    (read_done),
        .write_done   (write_done),
        .mtimecmp     (mtimecmp),
        .meip         (meip),
        .msip         (msip)
    );

    always #10 CLOCK_50 = !CLOCK_50;

    // fibonacci LFSR over taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = 64'd0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [63:0] model_load(input int byte_addr, input logic [2:0] code);
        int          nbytes;
        logic [63:0] v;
        nbytes = 1 << code[1:0];
        v      = 64'd0;
        for (int i = 0; i < nbytes; i++) begin
            v[8*i +: 8] = ram_model[byte_addr + i];   // little endian
        end
        if (!code[2] && nbytes < 8 && v[8*nbytes-1]) begin
            v = v | (~64'd0 << (8 * nbytes));
        end
        return v;
    endfunction

    task automatic model_store(input int byte_addr, input logic [1:0] size,
                               input logic [63:0] data);
        for (int i = 0; i < (1 << size); i++) begin
            ram_model[byte_addr + i] = data[8*i +: 8];
        end
    endtask

    task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
        test_checks++;
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    // entered and left 2 ns after a rising edge
    task automatic run_transfer(input logic wr, input logic [63:0] addr,
                                input logic [2:0] code, input logic [63:0] data,
                                output logic [63:0] rdata);
        int waited;
        address      = addr;
        ls_type.code = code;
        write_data   = data;
        if (wr) begin
            write_enable = 1'b1;
        end else begin
            read_enable = 1'b1;
        end
        @(posedge CLOCK_50);
        #2;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        waited       = 1;
        while (!(read_done && write_done) && waited < 8) begin
            @(posedge CLOCK_50);
            #2;
            waited++;
        end
        if (!(read_done && write_done)) begin
            $display("%s: transfer at address %h did not finish within 8 cycles",
                     test_name, addr);
            test_errors++;
        end
        rdata = read_data;
    endtask

    task automatic write_bus(input logic [63:0] addr, input logic [2:0] code,
                             input logic [63:0] data);
        logic [63:0] unused;
        run_transfer(1'b1, addr, code, data, unused);
    endtask

    task automatic read_bus(input logic [63:0] addr, input logic [2:0] code,
                            output logic [63:0] data);
        run_transfer(1'b0, addr, code, 64'd0, data);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #2;
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0t, the run did not reach its end", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [63:0] rd;
        logic [63:0] data;
        logic [9:0]  widx;
        logic [1:0]  size;
        logic [1:0]  offset;
        logic [31:0] en_m;
        logic [31:0] en_s;
        logic [63:0] base;
        logic        claimable;

        CLOCK_50      = 1'b0;
        KEY0          = 1'b0;
        address       = 64'd0;
        write_data    = 64'd0;
        ls_type.code  = 3'd0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        ext_irq       = 1'b0;
        pending_model = 32'd0;
        total_checks  = 0;
        total_errors  = 0;
        repeat (4) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        wait_cycles(1);

        begin_test("reset");
        check_value(64'd1, read_done);
        check_value(64'd1, write_done);
        check_value(64'd0, meip);
        check_value(64'd0, msip);
        check_value(`MTIMECMP_RESET, mtimecmp);
        write_bus(64'h7000_0000, 3'd2, 64'hdead_beef);   // unmapped write just completes
        read_bus(64'h7000_0000, 3'd2, rd);
        check_value(64'd0, rd);
        end_test();

        begin_test("ram_bytes");
        for (int n = 0; n < 20; n++) begin
            widx = rand_bits(10) & 10'h3fe;   // even so ld stays aligned
            for (int w = 0; w < 2; w++) begin
                data = rand_bits(32);
                write_bus(`RAM_BASE + 4 * (widx + w), 3'd2, data);
                model_store(4 * (widx + w), 2'd2, data);
            end
            size   = rand_bits(2) % 3;
            offset = (size == 2'd0) ? rand_bits(2) : (size == 2'd1) ? 2 * rand_bits(1) : 0;
            data   = rand_bits(32);
            write_bus(`RAM_BASE + 4 * widx + offset, {1'b0, size}, data);
            model_store(4 * widx + offset, size, data);
            for (int code = 0; code < 7; code++) begin
                size   = code[1:0];
                offset = (size == 2'd0) ? rand_bits(2) : (size == 2'd1) ? 2 * rand_bits(1) : 0;
                read_bus(`RAM_BASE + 4 * widx + offset, code[2:0], rd);
                check_value(model_load(4 * widx + offset, code[2:0]), rd);
            end
        end
        end_test();

        begin_test("ram_double");
        for (int n = 0; n < 10; n++) begin
            widx = (n == 0) ? `RAM_WORDS - 2 : rand_bits(10) & 10'h3fe;
            data = rand_bits(64);
            write_bus(`RAM_BASE + 4 * widx, 3'd3, data);
            model_store(4 * widx, 2'd3, data);
            read_bus(`RAM_BASE + 4 * widx, 3'd3, rd);
            check_value(model_load(4 * widx, 3'd3), rd);
        end
        end_test();

        begin_test("mtimecmp");
        data = rand_bits(64);
        write_bus(`MTIMECMP_ADDR, 3'd3, data);
        check_value(data, mtimecmp);
        read_bus(`MTIMECMP_ADDR, 3'd3, rd);
        check_value(data, rd);
        end_test();

        begin_test("plic_regs");
        for (int id = 0; id < `PLIC_SOURCES; id++) begin
            data = rand_bits(32);
            write_bus(`PLIC_BASE + 4 * id, 3'd2, data);
            read_bus(`PLIC_BASE + 4 * id, 3'd2, rd);
            check_value({61'd0, data[2:0]}, rd);   // priority is 3 bits wide
        end
        for (int c = 0; c < 2; c++) begin
            base = `PLIC_BASE + `PLIC_ENABLE_OFS + c * `PLIC_CTX_ENABLE_STRIDE;
            data = rand_bits(32);
            write_bus(base, 3'd2, data);
            read_bus(base, 3'd2, rd);
            check_value({32'd0, data[31:0]}, rd);
            base = `PLIC_BASE + `PLIC_THRESHOLD_OFS + c * `PLIC_CTX_STRIDE;
            data = rand_bits(32);
            write_bus(base, 3'd2, data);
            read_bus(base, 3'd2, rd);
            check_value({61'd0, data[2:0]}, rd);
        end
        end_test();

        begin_test("plic_claim");
        for (int r = 0; r < 4; r++) begin
            en_m = rand_bits(32);
            en_s = rand_bits(32);
            if (r == 0) begin
                en_m[1] = 1'b1;
            end
            if (r == 1) begin
                en_m[1] = 1'b0;   // only the supervisor context can claim
                en_s[1] = 1'b1;
            end
            write_bus(`PLIC_BASE + `PLIC_ENABLE_OFS, 3'd2, en_m);
            write_bus(`PLIC_BASE + `PLIC_ENABLE_OFS + `PLIC_CTX_ENABLE_STRIDE, 3'd2, en_s);
            ext_irq = 1'b1;
            wait_cycles(2);   // sync stage then edge capture
            pending_model[1] = 1'b1;
            check_value(pending_model[1] & en_m[1], meip);
            check_value(pending_model[1] & en_s[1], msip);
            read_bus(`PLIC_BASE + `PLIC_PENDING_OFS, 3'd2, rd);
            check_value({32'd0, pending_model}, rd);
            for (int c = 0; c < 3; c++) begin
                base      = `PLIC_BASE + `PLIC_CLAIM_OFS + (c % 2) * `PLIC_CTX_STRIDE;
                claimable = pending_model[1] & ((c % 2) ? en_s[1] : en_m[1]);
                read_bus(base, 3'd2, rd);
                check_value({63'd0, claimable}, rd);
                if (claimable) begin
                    pending_model[1] = 1'b0;
                end
            end
            check_value(pending_model[1] & en_m[1], meip);
            check_value(pending_model[1] & en_s[1], msip);
            ext_irq = 1'b0;
            wait_cycles(3);
        end
        end_test();

        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: source/soc_bus.sv
`timescale 1ns/1ns

module soc_bus import bus_pkg::*, plic_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] address,
    input  logic [63:0] write_data,
    input  ls_type_u    ls_type,
    input  logic        read_enable,
    input  logic        write_enable,
    input  logic        ext_irq,
    output logic [63:0] read_data,
    output logic        read_done,
    output logic        write_done,
    output logic [63:0] mtimecmp,
    output logic        meip,
    output logic        msip
);

    // bus_control to ram_port
    logic [63:0] ram_read_data;
    logic        ram_done;
    logic        ram_start;
    logic        ram_write;
    logic [9:0]  ram_word_index;
    logic [1:0]  ram_byte_offset;

    // bus_control to plic_regs
    logic [31:0] plic_read_data;
    logic        plic_read;
    logic        plic_write;
    plic_reg_e   plic_reg_sel;
    plic_ctx_e   plic_ctx;
    logic [2:0]  plic_source_id;

    bus_control i_bus_control (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .address         (address),
        .write_data      (write_data),
        .ls_type         (ls_type),
        .read_enable     (read_enable),
        .write_enable    (write_enable),
        .ram_read_data   (ram_read_data),
        .ram_done        (ram_done),
        .plic_read_data  (plic_read_data),
        .read_data       (read_data),
        .read_done       (read_done),
        .write_done      (write_done),
        .mtimecmp        (mtimecmp),
        .ram_start       (ram_start),
        .ram_write       (ram_write),
        .ram_word_index  (ram_word_index),
        .ram_byte_offset (ram_byte_offset),
        .plic_read       (plic_read),
        .plic_write      (plic_write),
        .plic_reg_sel    (plic_reg_sel),
        .plic_ctx        (plic_ctx),
        .plic_source_id  (plic_source_id)
    );

    ram_port #(
        .index_w (10)
    ) i_ram_port (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .access_start (ram_start),
        .write        (ram_write),
        .word_index   (ram_word_index),
        .byte_offset  (ram_byte_offset),
        .ls_type      (ls_type),
        .write_data   (write_data),
        .read_data    (ram_read_data),
        .access_done  (ram_done)
    );

    plic_regs i_plic_regs (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ext_irq      (ext_irq),
        .access_read  (plic_read),
        .access_write (plic_write),
        .reg_sel      (plic_reg_sel),
        .ctx          (plic_ctx),
        .source_id    (plic_source_id),
        .write_data   (write_data[31:0]),
        .read_data    (plic_read_data),
        .meip         (meip),
        .msip         (msip)
    );

endmodule

// File: plic/plic_regs.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module plic_regs import plic_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        ext_irq,
    input  logic        access_read,
    input  logic        access_write,
    input  plic_reg_e   reg_sel,
    input  plic_ctx_e   ctx,
    input  logic [2:0]  source_id,
    input  logic [31:0] write_data,
    output logic [31:0] read_data,
    output logic        meip,
    output logic        msip
);

    logic [2:0]  priority_q [`PLIC_SOURCES];
    logic [31:0] pending_q;
    logic [31:0] enable_q [plic_ctx_count];
    logic [2:0]  threshold_q [plic_ctx_count];  // kept for software only
    logic [31:0] claim_id [plic_ctx_count];
    logic        irq_sync;
    logic        irq_prev;
    logic        irq_edge;

    assign irq_edge = irq_sync && !irq_prev;

    // only source 1 can be claimed
    always_comb begin
        for (int c = 0; c < plic_ctx_count; c++) begin
            claim_id[c] = (pending_q[plic_ext_id] && enable_q[c][plic_ext_id]) ?
                          plic_ext_id : 32'd0;
        end
    end

    assign meip = (claim_id[ctx_m] != 32'd0);
    assign msip = (claim_id[ctx_s] != 32'd0);

    always_comb begin
        read_data = 32'd0;
        case (reg_sel)
            reg_priority: begin
                if (source_id < `PLIC_SOURCES) begin
                    read_data = {29'd0, priority_q[source_id]};
                end
            end
            reg_pending:   read_data = pending_q;
            reg_enable:    read_data = enable_q[ctx];
            reg_threshold: read_data = {29'd0, threshold_q[ctx]};
            reg_claim:     read_data = claim_id[ctx];
            default:       read_data = 32'd0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_sync  <= 1'b0;
            irq_prev  <= 1'b0;
            pending_q <= 32'd0;
            for (int c = 0; c < plic_ctx_count; c++) begin
                enable_q[c]    <= 32'd0;
                threshold_q[c] <= 3'd0;
            end
            for (int s = 0; s < `PLIC_SOURCES; s++) begin
                priority_q[s] <= 3'd0;
            end
        end else begin
            irq_sync <= ext_irq;
            irq_prev <= irq_sync;
            if (access_write) begin
                case (reg_sel)
                    reg_priority: begin
                        if (source_id < `PLIC_SOURCES) begin
                            priority_q[source_id] <= write_data[2:0];
                        end
                    end
                    reg_enable:    enable_q[ctx]    <= write_data;
                    reg_threshold: threshold_q[ctx] <= write_data[2:0];
                    default:       ;  // pending is read only and claim writes do nothing
                endcase
            end
            if (access_read && reg_sel == reg_claim && claim_id[ctx] != 32'd0) begin
                pending_q[claim_id[ctx][4:0]] <= 1'b0;
            end
            if (irq_edge) begin
                pending_q[plic_ext_id] <= 1'b1;  // new edge beats a same-cycle claim
            end
        end
    end

    // bus_control never reads and writes the PLIC in one cycle
    a_single_access: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(access_read && access_write));

endmodule

// File: ram/ram_port.sv
`timescale 1ns/1ns

module ram_port import bus_pkg::*; #(
    parameter int index_w = 10
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               access_start,
    input  logic               write,
    input  logic [index_w-1:0] word_index,
    input  logic [1:0]         byte_offset,
    input  ls_type_u           ls_type,
    input  logic [63:0]        write_data,
    output logic [63:0]        read_data,
    output logic               access_done
);

    logic [31:0]        mem [2**index_w];
    logic               step_q;       // high during the upper word of a doubleword
    logic               beat_active;
    logic [index_w-1:0] beat_index;
    logic [3:0]         lane_en;
    logic [31:0]        lane_data;
    logic [31:0]        rd_word;
    logic [31:0]        shifted;
    logic [63:0]        load_value;
    logic               aligned;

    assign beat_active = access_start || step_q;
    assign beat_index  = step_q ? word_index + 1'b1 : word_index;
    assign rd_word     = mem[beat_index];
    assign shifted     = rd_word >> {byte_offset, 3'b000};

    // byte lanes covered by the store
    always_comb begin
        lane_en   = 4'b1111;
        lane_data = write_data[31:0];
        if (step_q) begin
            lane_data = write_data[63:32];
        end else begin
            case (ls_type.fields.size)
                ls_byte: begin
                    lane_en   = 4'b0001 << byte_offset;
                    lane_data = {4{write_data[7:0]}};
                end
                ls_half: begin
                    lane_en   = 4'b0011 << byte_offset;
                    lane_data = {2{write_data[15:0]}};
                end
                default: lane_en = 4'b1111;  // sw and sd low word
            endcase
        end
    end

    // load extraction with sign or zero extension
    always_comb begin
        case (ls_type.fields.size)
            ls_byte: load_value = ls_type.fields.is_unsigned ?
                                  {56'd0, shifted[7:0]} : {{56{shifted[7]}}, shifted[7:0]};
            ls_half: load_value = ls_type.fields.is_unsigned ?
                                  {48'd0, shifted[15:0]} : {{48{shifted[15]}}, shifted[15:0]};
            ls_word: load_value = ls_type.fields.is_unsigned ?
                                  {32'd0, shifted} : {{32{shifted[31]}}, shifted};
            default: load_value = {32'd0, rd_word};  // upper half follows on beat two
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step_q      <= 1'b0;
            access_done <= 1'b0;
        end else begin
            access_done <= 1'b0;
            if (access_start && ls_type.fields.size == ls_double) begin
                step_q <= 1'b1;
            end else if (access_start || step_q) begin
                step_q      <= 1'b0;
                access_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat_active) begin
            if (write) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) begin
                        mem[beat_index][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end else if (step_q) begin
                read_data[63:32] <= rd_word;
            end else begin
                read_data <= load_value;
            end
        end
    end

    // natural alignment, doubleword on an even word
    always_comb begin
        case (ls_type.fields.size)
            ls_byte: aligned = 1'b1;
            ls_half: aligned = !byte_offset[0];
            ls_word: aligned = (byte_offset == 2'd0);
            default: aligned = (byte_offset == 2'd0) && !word_index[0];
        endcase
    end

    a_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        access_start |-> aligned && ls_type.code != ls_code_invalid);

endmodule

// File: source/bus_control.sv
`timescale 1ns/1ns
`include "soc_defs.svh"

module bus_control import bus_pkg::*, plic_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] address,
    input  logic [63:0] write_data,
    input  ls_type_u    ls_type,
    input  logic        read_enable,
    input  logic        write_enable,
    input  logic [63:0] ram_read_data,
    input  logic        ram_done,
    input  logic [31:0] plic_read_data,
    output logic [63:0] read_data,
    output logic        read_done,
    output logic        write_done,
    output logic [63:0] mtimecmp,
    output logic        ram_start,
    output logic        ram_write,
    output logic [9:0]  ram_word_index,
    output logic [1:0]  ram_byte_offset,
    output logic        plic_read,
    output logic        plic_write,
    output plic_reg_e   plic_reg_sel,
    output plic_ctx_e   plic_ctx,
    output logic [2:0]  plic_source_id
);

    localparam logic [63:0] ram_end = `RAM_BASE + 4 * `RAM_WORDS;

    logic [63:0] ram_ofs;
    logic [63:0] plic_ofs;
    logic [63:0] ram_limit;
    bus_target_e target;
    plic_reg_e   dec_reg;
    plic_ctx_e   dec_ctx;
    logic [2:0]  dec_source;
    bus_target_e target_q;     // where the running transfer goes
    logic        busy;
    logic        finish;

    assign ram_ofs  = address - `RAM_BASE;
    assign plic_ofs = address - `PLIC_BASE;

    // a doubleword needs its second word inside the window too
    assign ram_limit = (ls_type.fields.size == ls_double) ? ram_end - 64'd4 : ram_end;

    // address decode
    always_comb begin
        target     = tgt_none;
        dec_reg    = reg_priority;
        dec_ctx    = ctx_m;
        dec_source = plic_ofs[4:2];  // id = offset / 4
        if (address >= `RAM_BASE && address < ram_limit) begin
            target = tgt_ram;
        end else if (address == `MTIMECMP_ADDR) begin
            target = tgt_mtimecmp;
        end else if (plic_ofs < 4 * `PLIC_SOURCES) begin
            target = tgt_plic;
        end else if (plic_ofs == `PLIC_PENDING_OFS) begin
            target  = tgt_plic;
            dec_reg = reg_pending;
        end else begin
            for (int c = 0; c < plic_ctx_count; c++) begin
                if (plic_ofs == `PLIC_ENABLE_OFS + c * `PLIC_CTX_ENABLE_STRIDE) begin
                    target  = tgt_plic;
                    dec_reg = reg_enable;
                    dec_ctx = plic_ctx_e'(c);
                end
                if (plic_ofs == `PLIC_THRESHOLD_OFS + c * `PLIC_CTX_STRIDE) begin
                    target  = tgt_plic;
                    dec_reg = reg_threshold;
                    dec_ctx = plic_ctx_e'(c);
                end
                if (plic_ofs == `PLIC_CLAIM_OFS + c * `PLIC_CTX_STRIDE) begin
                    target  = tgt_plic;
                    dec_reg = reg_claim;
                    dec_ctx = plic_ctx_e'(c);
                end
            end
        end
    end

    assign busy   = !read_done || !write_done;
    assign finish = (target_q == tgt_ram) ? ram_done : 1'b1;  // others take one cycle

    // done flags, strobes and mtimecmp
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
            target_q   <= tgt_none;
            ram_start  <= 1'b0;
            plic_read  <= 1'b0;
            plic_write <= 1'b0;
            mtimecmp   <= `MTIMECMP_RESET;
        end else begin
            ram_start  <= 1'b0;
            plic_read  <= 1'b0;
            plic_write <= 1'b0;
            if (read_enable || write_enable) begin
                if (read_enable) begin
                    read_done <= 1'b0;
                end else begin
                    write_done <= 1'b0;
                end
                target_q   <= target;
                ram_start  <= (target == tgt_ram);
                plic_read  <= (target == tgt_plic) && read_enable;
                plic_write <= (target == tgt_plic) && !read_enable;
            end else if (busy && finish) begin
                read_done  <= 1'b1;
                write_done <= 1'b1;
                if (!write_done && target_q == tgt_mtimecmp) begin
                    mtimecmp <= write_data;
                end
            end
        end
    end

    // transfer fields and read return
    always_ff @(posedge CLOCK_50) begin
        if (read_enable || write_enable) begin
            ram_write       <= !read_enable;
            ram_word_index  <= ram_ofs[11:2];
            ram_byte_offset <= ram_ofs[1:0];
            plic_reg_sel    <= dec_reg;
            plic_ctx        <= dec_ctx;
            plic_source_id  <= dec_source;
        end
        if (busy && finish && !read_done) begin
            case (target_q)
                tgt_ram:      read_data <= ram_read_data;
                tgt_plic:     read_data <= {32'd0, plic_read_data};
                tgt_mtimecmp: read_data <= mtimecmp;
                default:      read_data <= 64'd0;  // unmapped
            endcase
        end
    end

    // the master waits for both flags before the next transfer
    a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_enable || write_enable) |-> (read_done && write_done));

    // ram_port answers within two cycles, doubleword included
    a_ram_answers: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram_start |-> ##[1:2] ram_done);

endmodule

// File: common/plic_pkg.sv
package plic_pkg;

    // context 0 is hart 0 machine mode, context 1 is hart 0 supervisor mode
    typedef enum logic {
        ctx_m = 1'b0,
        ctx_s = 1'b1
    } plic_ctx_e;

    typedef enum logic [2:0] {
        reg_priority  = 3'd0,
        reg_pending   = 3'd1,
        reg_enable    = 3'd2,
        reg_threshold = 3'd3,
        reg_claim     = 3'd4
    } plic_reg_e;

    localparam int plic_ctx_count = 2;

    // ext_irq is wired to this source id
    localparam int plic_ext_id = 1;

endpackage

// File: common/bus_pkg.sv
package bus_pkg;

    // access width in the low two bits of the load/store type
    typedef enum logic [1:0] {
        ls_byte   = 2'd0,
        ls_half   = 2'd1,
        ls_word   = 2'd2,
        ls_double = 2'd3
    } ls_size_e;

    typedef struct packed {
        logic     is_unsigned;  // lbu lhu lwu
        ls_size_e size;
    } ls_fields_t;

    // loads use 0 lb 1 lh 2 lw 3 ld 4 lbu 5 lhu 6 lwu
    // stores use 0 sb 1 sh 2 sw 3 sd
    typedef union packed {
        logic [2:0] code;
        ls_fields_t fields;
    } ls_type_u;

    // an unsigned doubleword has no meaning
    localparam logic [2:0] ls_code_invalid = 3'd7;

    typedef enum logic [1:0] {
        tgt_none     = 2'd0,
        tgt_ram      = 2'd1,
        tgt_plic     = 2'd2,
        tgt_mtimecmp = 2'd3
    } bus_target_e;

endpackage

// File: common/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// on-chip RAM window
`define RAM_BASE                64'h0000_1000
`define RAM_WORDS               1024            // 32-bit words

// machine timer compare register
`define MTIMECMP_ADDR           64'h0200_4000
`define MTIMECMP_RESET          64'h8000_0000

// PLIC window
`define PLIC_BASE               64'h0C00_0000

// offsets below are relative to PLIC_BASE
`define PLIC_PENDING_OFS        64'h0000_1000   // global pending bitmap
`define PLIC_ENABLE_OFS         64'h0000_2000
`define PLIC_CTX_ENABLE_STRIDE  64'h0000_0080   // enable block per context
`define PLIC_THRESHOLD_OFS      64'h0020_0000
`define PLIC_CLAIM_OFS          64'h0020_0004
`define PLIC_CTX_STRIDE         64'h0000_1000   // threshold and claim per context

// priority slots for ids 0 to 5
`define PLIC_SOURCES            6

`endif
